// ==== compile.f ====
hw/qkv_pkg.sv
hw/qkv_ctrl.sv
hw/input_addr_gen.sv
hw/weight_addr_gen.sv
hw/mac_writer.sv
hw/qkv_proj_top.sv
sim/qkv_proj_asserts.sv
sim/tb_qkv_proj.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the QKV projection testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=sim_qkv_proj

verilator --binary --timing --assert -f compile.f \
  --top-module tb_qkv_proj -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
  exit 0
fi
exit 1

// ==== sim/tb_qkv_proj.sv ====
// Testbench for the QKV projection block with SRAM models and a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_qkv_proj;

  localparam int NUM_PROJ   = 3;
  localparam int NUM_CASES  = 4;
  localparam int MEM_WORDS  = 4096;
  localparam int WAIT_LIMIT = 1000;

  // Stimulus table with M, K, N, a stray dut_valid flag, expected writes and latency
  int   case_m[NUM_CASES]           = '{1, 2, 3, 4};
  int   case_k[NUM_CASES]           = '{1, 3, 2, 4};
  int   case_n[NUM_CASES]           = '{1, 2, 4, 1};
  logic case_extra_valid[NUM_CASES] = '{1'b0, 1'b0, 1'b1, 1'b1};
  int   case_writes[NUM_CASES]      = '{3, 12, 36, 12};
  int   case_latency[NUM_CASES]     = '{6, 39, 75, 51};

  logic           clk = 1'b0;
  logic           reset_n;
  logic           dut_valid;
  logic           dut_ready;
  qkv_pkg::addr_t input_read_address;
  qkv_pkg::data_t input_read_data = '0;
  qkv_pkg::addr_t weight_read_address;
  qkv_pkg::data_t weight_read_data = '0;
  logic           result_write_enable;
  qkv_pkg::addr_t result_write_address;
  qkv_pkg::data_t result_write_data;

  qkv_pkg::data_t input_mem[MEM_WORDS];
  qkv_pkg::data_t weight_mem[MEM_WORDS];
  qkv_pkg::data_t result_mem[MEM_WORDS];
  qkv_pkg::data_t expected_q[$];
  int             write_count;
  logic [15:0]    lfsr_state = 16'd87;

  qkv_proj_top #(
    .NUM_PROJ (NUM_PROJ)
  ) dut_i (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dut_valid            (dut_valid),
    .dut_ready            (dut_ready),
    .input_read_address   (input_read_address),
    .input_read_data      (input_read_data),
    .weight_read_address  (weight_read_address),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  always #5 clk = ~clk;

  // Registered SRAM reads
  always @(posedge clk) begin
    input_read_data  <= input_mem[input_read_address];
    weight_read_data <= weight_mem[weight_read_address];
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input qkv_pkg::data_t got,
                            input qkv_pkg::data_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input qkv_pkg::addr_t got,
                            input qkv_pkg::addr_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error: %s got 0x%03h expected 0x%03h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_now($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Result SRAM model that checks each write against the running index
  always @(negedge clk) begin
    if (result_write_enable === 1'b1) begin
      if (dut_ready) begin
        fail_now("a result write happened while dut_ready was high");
      end
      if (write_count >= expected_q.size()) begin
        fail_now("more result writes than the job should produce");
      end
      check_addr("result_write_address", result_write_address,
                 qkv_pkg::addr_t'(write_count));
      check_data("result_write_data", result_write_data, expected_q[write_count]);
      result_mem[result_write_address] = result_write_data;
      write_count = write_count + 1;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] value;
    int         i;
    value = '0;
    for (i = 0; i < 8; i++) begin
      value      = {value[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Fill both operand SRAMs and build the expected results in write order
  task automatic load_case(input int m, input int k, input int n);
    int             a;
    int             p;
    int             r;
    int             j;
    int             kk;
    qkv_pkg::data_t sum;
    for (a = 0; a < MEM_WORDS; a++) begin
      input_mem[a]  = 32'ha500_0000 | a;
      weight_mem[a] = 32'h5a00_0000 | a;
      result_mem[a] = 32'hdead_0000 ^ a;
    end
    input_mem[0]  = {qkv_pkg::dim_t'(m), qkv_pkg::dim_t'(k)};
    weight_mem[0] = {qkv_pkg::dim_t'(k), qkv_pkg::dim_t'(n)};
    for (a = 0; a < m * k; a++) begin
      input_mem[1 + a] = {24'h0, random_byte()};
    end
    for (a = 0; a < NUM_PROJ * k * n; a++) begin
      weight_mem[1 + a] = {24'h0, random_byte()};
    end
    expected_q.delete();
    write_count = 0;
    for (p = 0; p < NUM_PROJ; p++) begin
      for (r = 0; r < m; r++) begin
        for (j = 0; j < n; j++) begin
          sum = '0;
          for (kk = 0; kk < k; kk++) begin
            sum = sum + input_mem[1 + r * k + kk] * weight_mem[1 + p * k * n + j * k + kk];
          end
          expected_q.push_back(sum);
        end
      end
    end
  endtask

  task automatic run_case(input int idx);
    int cycles;
    int i;
    load_case(case_m[idx], case_k[idx], case_n[idx]);
    dut_valid = 1'b1;
    next_cycle();
    dut_valid = 1'b0;
    check_flag("dut_ready", dut_ready, 1'b0);
    cycles = 0;
    while (!dut_ready) begin
      if (cycles >= WAIT_LIMIT) begin
        fail_now("timed out waiting for dut_ready to return after a job");
      end
      // Stray start request in the middle of COMPUTE
      dut_valid = case_extra_valid[idx] && (cycles == 4);
      next_cycle();
      cycles = cycles + 1;
    end
    dut_valid = 1'b0;
    check_count("cycles to dut_ready", cycles, case_latency[idx]);
    check_count("result write count", write_count, case_writes[idx]);
    for (i = 0; i < expected_q.size(); i++) begin
      check_data("result_mem", result_mem[i], expected_q[i]);
    end
  endtask

  initial begin
    int i;
    reset_n     = 1'b0;
    dut_valid   = 1'b0;
    write_count = 0;
    repeat (16) next_cycle();
    check_flag("dut_ready", dut_ready, 1'b1);
    check_addr("input_read_address", input_read_address, '0);
    check_addr("weight_read_address", weight_read_address, '0);
    check_flag("result_write_enable", result_write_enable, 1'b0);
    reset_n = 1'b1;
    repeat (4) begin
      next_cycle();
      check_flag("dut_ready", dut_ready, 1'b1);
    end
    // Jobs run back to back
    for (i = 0; i < NUM_CASES; i++) begin
      run_case(i);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/qkv_proj_asserts.sv ====
// Concurrent checks on the controller strobes and the result write port
`timescale 1ns/1ps
`default_nettype none

module qkv_proj_asserts (
  input logic clk,
  input logic reset_n,
  input logic fetch_step,
  input logic dot_end,
  input logic row_end,
  input logic matrix_end,
  input logic dut_ready,
  input logic result_write_enable
);

  // End strobes only ride on a fetch
  assert property (@(posedge clk) disable iff (!reset_n) dot_end |-> fetch_step)
    else $error("dot_end asserted without fetch_step");
  assert property (@(posedge clk) disable iff (!reset_n) row_end |-> fetch_step)
    else $error("row_end asserted without fetch_step");
  assert property (@(posedge clk) disable iff (!reset_n) matrix_end |-> fetch_step)
    else $error("matrix_end asserted without fetch_step");

  // Nesting of the end strobes
  assert property (@(posedge clk) disable iff (!reset_n) matrix_end |-> row_end)
    else $error("matrix_end asserted without row_end");
  assert property (@(posedge clk) disable iff (!reset_n) row_end |-> dot_end)
    else $error("row_end asserted without dot_end");

  // Writes only happen inside a job
  assert property (@(posedge clk) disable iff (!reset_n) !(result_write_enable && dut_ready))
    else $error("result write while dut_ready is high");

endmodule

// Strobes between qkv_ctrl and mac_writer meet here
bind qkv_proj_top qkv_proj_asserts asserts_i (
  .clk                 (clk),
  .reset_n             (reset_n),
  .fetch_step          (fetch_step),
  .dot_end             (dot_end),
  .row_end             (row_end),
  .matrix_end          (matrix_end),
  .dut_ready           (dut_ready),
  .result_write_enable (result_write_enable)
);

`default_nettype wire

// ==== hw/qkv_proj_top.sv ====
// QKV projection top level joining the controller, address generators and MAC writer
`timescale 1ns/1ps
`default_nettype none

module qkv_proj_top #(
  parameter int NUM_PROJ = 3
) (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           dut_valid,
  output logic           dut_ready,
  output qkv_pkg::addr_t input_read_address,
  input  qkv_pkg::data_t input_read_data,
  output qkv_pkg::addr_t weight_read_address,
  input  qkv_pkg::data_t weight_read_data,
  output logic           result_write_enable,
  output qkv_pkg::addr_t result_write_address,
  output qkv_pkg::data_t result_write_data
);

  logic fetch_start;
  logic fetch_step;
  logic dot_end;
  logic row_end;
  logic matrix_end;
  logic job_start;

  qkv_ctrl #(
    .NUM_PROJ (NUM_PROJ)
  ) ctrl_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .dut_valid        (dut_valid),
    .input_read_data  (input_read_data),
    .weight_read_data (weight_read_data),
    .dut_ready        (dut_ready),
    .fetch_start      (fetch_start),
    .fetch_step       (fetch_step),
    .dot_end          (dot_end),
    .row_end          (row_end),
    .matrix_end       (matrix_end),
    .job_start        (job_start)
  );

  input_addr_gen input_addr_gen_i (
    .clk                (clk),
    .reset_n            (reset_n),
    .fetch_start        (fetch_start),
    .fetch_step         (fetch_step),
    .dot_end            (dot_end),
    .row_end            (row_end),
    .matrix_end         (matrix_end),
    .input_read_address (input_read_address)
  );

  weight_addr_gen weight_addr_gen_i (
    .clk                 (clk),
    .reset_n             (reset_n),
    .fetch_start         (fetch_start),
    .fetch_step          (fetch_step),
    .row_end             (row_end),
    .matrix_end          (matrix_end),
    .weight_read_address (weight_read_address)
  );

  mac_writer mac_writer_i (
    .clk                  (clk),
    .reset_n              (reset_n),
    .fetch_step           (fetch_step),
    .dot_end              (dot_end),
    .job_start            (job_start),
    .input_read_data      (input_read_data),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

endmodule

`default_nettype wire

// ==== hw/mac_writer.sv ====
// Multiply-accumulate stage that sums operand pairs and writes each result in order
`timescale 1ns/1ps
`default_nettype none

module mac_writer (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           fetch_step,
  input  logic           dot_end,
  input  logic           job_start,
  input  qkv_pkg::data_t input_read_data,
  input  qkv_pkg::data_t weight_read_data,
  output logic           result_write_enable,
  output qkv_pkg::addr_t result_write_address,
  output qkv_pkg::data_t result_write_data
);

  // Strobes delayed to meet the SRAM read data
  logic step_d;
  logic dot_d;

  qkv_pkg::data_t acc;
  qkv_pkg::data_t product;

  // Wraps at 32 bits
  assign product = input_read_data * weight_read_data;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      step_d              <= 1'b0;
      dot_d               <= 1'b0;
      result_write_enable <= 1'b0;
    end else begin
      step_d              <= fetch_step;
      dot_d               <= dot_end;
      result_write_enable <= dot_d;
    end
  end

  always_ff @(posedge clk) begin
    if (job_start || dot_d) begin
      acc <= '0;
    end else if (step_d) begin
      acc <= acc + product;
    end
  end

  // Finished sum includes the last product
  always_ff @(posedge clk) begin
    if (dot_d) begin
      result_write_data <= acc + product;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || job_start) begin
      result_write_address <= '0;
    end else if (result_write_enable) begin
      result_write_address <= result_write_address + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/weight_addr_gen.sv ====
// Weight SRAM address walker, column by column through each weight matrix
`timescale 1ns/1ps
`default_nettype none

module weight_addr_gen (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           fetch_start,
  input  logic           fetch_step,
  input  logic           row_end,
  input  logic           matrix_end,
  output qkv_pkg::addr_t weight_read_address
);

  // First word of the current weight matrix
  qkv_pkg::addr_t matrix_base;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      weight_read_address <= '0;
      matrix_base         <= '0;
    end else if (fetch_start) begin
      weight_read_address <= qkv_pkg::addr_t'(1);
      matrix_base         <= qkv_pkg::addr_t'(1);
    end else if (fetch_step) begin
      if (matrix_end) begin
        // Matrices are packed back to back
        weight_read_address <= weight_read_address + 1'b1;
        matrix_base         <= weight_read_address + 1'b1;
      end else if (row_end) begin
        // Same weights again for the next input row
        weight_read_address <= matrix_base;
      end else begin
        // Columns are contiguous, so a finished dot product just moves on
        weight_read_address <= weight_read_address + 1'b1;
      end
    end else begin
      weight_read_address <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/input_addr_gen.sv ====
// Input SRAM address walker, row by row, rewinding the row for each output column
`timescale 1ns/1ps
`default_nettype none

module input_addr_gen (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           fetch_start,
  input  logic           fetch_step,
  input  logic           dot_end,
  input  logic           row_end,
  input  logic           matrix_end,
  output qkv_pkg::addr_t input_read_address
);

  // Address of element (r, 0) of the current input row
  qkv_pkg::addr_t row_base;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      input_read_address <= '0;
      row_base           <= '0;
    end else if (fetch_start) begin
      input_read_address <= qkv_pkg::addr_t'(1);
      row_base           <= qkv_pkg::addr_t'(1);
    end else if (fetch_step) begin
      if (matrix_end) begin
        // Next projection reads the same input from the top
        input_read_address <= qkv_pkg::addr_t'(1);
        row_base           <= qkv_pkg::addr_t'(1);
      end else if (row_end) begin
        input_read_address <= input_read_address + 1'b1;
        row_base           <= input_read_address + 1'b1;
      end else if (dot_end) begin
        input_read_address <= row_base;
      end else begin
        input_read_address <= input_read_address + 1'b1;
      end
    end else begin
      // Park on word 0 between jobs
      input_read_address <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/qkv_ctrl.sv ====
// QKV job controller with dimension capture, nested loop counters and fetch strobes
`timescale 1ns/1ps
`default_nettype none

module qkv_ctrl #(
  parameter int NUM_PROJ = 3
) (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           dut_valid,
  input  qkv_pkg::data_t input_read_data,
  input  qkv_pkg::data_t weight_read_data,
  output logic           dut_ready,
  output logic           fetch_start,
  output logic           fetch_step,
  output logic           dot_end,
  output logic           row_end,
  output logic           matrix_end,
  output logic           job_start
);

  localparam qkv_pkg::dim_t LAST_PROJ = qkv_pkg::dim_t'(NUM_PROJ - 1);

  qkv_pkg::ctrl_state_t state;
  qkv_pkg::ctrl_state_t state_next;

  // Captured dimensions: M rows, K inner, N weight columns
  qkv_pkg::dim_t m_dim;
  qkv_pkg::dim_t k_dim;
  qkv_pkg::dim_t n_dim;

  // Loop indices, k innermost and p outermost
  qkv_pkg::dim_t k_idx;
  qkv_pkg::dim_t j_idx;
  qkv_pkg::dim_t r_idx;
  qkv_pkg::dim_t p_idx;

  logic last_fetch;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= qkv_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      qkv_pkg::IDLE: begin
        if (dut_valid) begin
          state_next = qkv_pkg::LOAD_DIMS;
        end
      end
      qkv_pkg::LOAD_DIMS: begin
        state_next = qkv_pkg::COMPUTE;
      end
      qkv_pkg::COMPUTE: begin
        if (last_fetch) begin
          state_next = qkv_pkg::DRAIN_READ;
        end
      end
      // Last product arrives, then the last write goes out
      qkv_pkg::DRAIN_READ: begin
        state_next = qkv_pkg::DRAIN_WRITE;
      end
      qkv_pkg::DRAIN_WRITE: begin
        state_next = qkv_pkg::IDLE;
      end
      default: begin
        state_next = qkv_pkg::IDLE;
      end
    endcase
  end

  assign dut_ready   = (state == qkv_pkg::IDLE);
  assign fetch_start = (state == qkv_pkg::LOAD_DIMS);
  assign job_start   = fetch_start;
  assign fetch_step  = (state == qkv_pkg::COMPUTE);

  // End strobes nest: matrix implies row implies dot
  assign dot_end    = fetch_step && (k_idx == k_dim - 1'b1);
  assign row_end    = dot_end && (j_idx == n_dim - 1'b1);
  assign matrix_end = row_end && (r_idx == m_dim - 1'b1);
  assign last_fetch = matrix_end && (p_idx == LAST_PROJ);

  // Word 0 holds rows in the upper half and columns in the lower half
  always_ff @(posedge clk) begin
    if (state == qkv_pkg::LOAD_DIMS) begin
      m_dim <= input_read_data[31:16];
      k_dim <= input_read_data[15:0];
      n_dim <= weight_read_data[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || fetch_start) begin
      k_idx <= '0;
      j_idx <= '0;
      r_idx <= '0;
      p_idx <= '0;
    end else if (fetch_step) begin
      k_idx <= dot_end ? '0 : k_idx + 1'b1;
      if (dot_end) begin
        j_idx <= row_end ? '0 : j_idx + 1'b1;
      end
      if (row_end) begin
        r_idx <= matrix_end ? '0 : r_idx + 1'b1;
      end
      if (matrix_end) begin
        p_idx <= last_fetch ? '0 : p_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/qkv_pkg.sv ====
// QKV projection package with SRAM widths, word types and controller states
`default_nettype none

package qkv_pkg;

  // SRAM word and address widths
  parameter int DATA_W = 32;
  parameter int ADDR_W = 12;

  // Each dimension field is half a word
  parameter int DIM_W = DATA_W / 2;

  // One SRAM word or one result element
  typedef logic [DATA_W-1:0] data_t;

  // SRAM word address
  typedef logic [ADDR_W-1:0] addr_t;

  // Matrix dimension or loop index
  typedef logic [DIM_W-1:0] dim_t;

  // Job controller states
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    LOAD_DIMS   = 3'd1,
    COMPUTE     = 3'd2,
    DRAIN_READ  = 3'd3,
    DRAIN_WRITE = 3'd4
  } ctrl_state_t;

endpackage

`default_nettype wire
